// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
(
    input  rv_pkg::alu_op_e i_op,
    input  rv_pkg::data_t   i_a,
    input  rv_pkg::data_t   i_b,
    output rv_pkg::data_t   o_result
);

    import rv_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = i_b[SHAMT_W-1:0];                // Upper bits of B ignored

    always_comb
    begin
        unique case (i_op)
            alu_add:
                o_result = i_a + i_b;
            alu_sub:
                o_result = i_a - i_b;
            alu_sll:
                o_result = i_a << shamt;
            alu_slt:
                o_result = data_t'($signed(i_a) < $signed(i_b));
            alu_sltu:
                o_result = data_t'(i_a < i_b);
            alu_xor:
                o_result = i_a ^ i_b;
            alu_srl:
                o_result = i_a >> shamt;
            alu_sra:
                o_result = data_t'($signed(i_a) >>> shamt);  // Sign fill
            alu_or:
                o_result = i_a | i_b;
            alu_and:
                o_result = i_a & i_b;
            alu_pass_b:
                o_result = i_b;                     // LUI immediate
            default:
                o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
(
    input  rv_pkg::inst_u   i_inst,
    output rv_pkg::decode_t o_decode
);

    import rv_pkg::*;

    data_t imm_i;
    data_t imm_s;
    data_t imm_b;
    data_t imm_j;
    data_t imm_u;
    data_t imm_shamt;

    // Shared by OP and OP-IMM where alt selects SUB or SRA
    function automatic alu_op_e alu_op_of(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        op = alu_add;
        case (funct3)
            funct3_add_sub: op = alt ? alu_sub : alu_add;
            funct3_sll:     op = alu_sll;
            funct3_slt:     op = alu_slt;
            funct3_sltu:    op = alu_sltu;
            funct3_xor:     op = alu_xor;
            funct3_sr:      op = alt ? alu_sra : alu_srl;
            funct3_or:      op = alu_or;
            funct3_and:     op = alu_and;
        endcase
        return op;
    endfunction

    assign imm_i = {{20{i_inst.i_fmt.imm[11]}}, i_inst.i_fmt.imm};
    assign imm_s = {{20{i_inst.s_fmt.imm_hi[6]}}, i_inst.s_fmt.imm_hi, i_inst.s_fmt.imm_lo};
    assign imm_b = {{20{i_inst.s_fmt.imm_hi[6]}}, i_inst.s_fmt.imm_lo[0],
                    i_inst.s_fmt.imm_hi[5:0], i_inst.s_fmt.imm_lo[4:1], 1'b0};
    assign imm_j = {{12{i_inst.u_fmt.imm[19]}}, i_inst.u_fmt.imm[7:0], i_inst.u_fmt.imm[8],
                    i_inst.u_fmt.imm[18:9], 1'b0};
    assign imm_u = {i_inst.u_fmt.imm, 12'b0};
    assign imm_shamt = {{(XLEN-REG_ADDR_W){1'b0}}, i_inst.r_fmt.rs2};

    always_comb
    begin
        o_decode.rs1        = i_inst.r_fmt.rs1;
        o_decode.rs2        = i_inst.r_fmt.rs2;
        o_decode.rd         = i_inst.r_fmt.rd;
        o_decode.imm        = '0;
        o_decode.alu_op     = alu_add;
        o_decode.use_imm    = 1'b0;
        o_decode.use_pc     = 1'b0;
        o_decode.inst_class = class_illegal;

        unique casez ({i_inst.r_fmt.funct7, i_inst.r_fmt.funct3, i_inst.r_fmt.opcode})
            {7'b???????, 3'b???, opcode_lui}:
            begin
                o_decode.imm        = imm_u;
                o_decode.alu_op     = alu_pass_b;
                o_decode.use_imm    = 1'b1;
                o_decode.inst_class = class_upper;
            end

            {7'b???????, 3'b???, opcode_auipc}:
            begin
                o_decode.imm        = imm_u;
                o_decode.use_imm    = 1'b1;
                o_decode.use_pc     = 1'b1;         // pc + imm
                o_decode.inst_class = class_upper;
            end

            {7'b???????, 3'b???, opcode_jal}:
            begin
                o_decode.imm        = imm_j;
                o_decode.inst_class = class_deferred;
            end

            {7'b???????, 3'b000, opcode_jalr},
            {7'b???????, 3'b000, opcode_load},      // LB
            {7'b???????, 3'b001, opcode_load},      // LH
            {7'b???????, 3'b010, opcode_load},      // LW
            {7'b???????, 3'b100, opcode_load},      // LBU
            {7'b???????, 3'b101, opcode_load}:      // LHU
            begin
                o_decode.imm        = imm_i;
                o_decode.inst_class = class_deferred;
            end

            {7'b???????, 3'b000, opcode_branch},    // BEQ
            {7'b???????, 3'b001, opcode_branch},    // BNE
            {7'b???????, 3'b100, opcode_branch},    // BLT
            {7'b???????, 3'b101, opcode_branch},    // BGE
            {7'b???????, 3'b110, opcode_branch},    // BLTU
            {7'b???????, 3'b111, opcode_branch}:    // BGEU
            begin
                o_decode.imm        = imm_b;
                o_decode.inst_class = class_deferred;
            end

            {7'b???????, 3'b000, opcode_store},     // SB
            {7'b???????, 3'b001, opcode_store},     // SH
            {7'b???????, 3'b010, opcode_store}:     // SW
            begin
                o_decode.imm        = imm_s;
                o_decode.inst_class = class_deferred;
            end

            {funct7_base, funct3_sll, opcode_op_imm},   // SLLI
            {funct7_base, funct3_sr,  opcode_op_imm},   // SRLI
            {funct7_alt,  funct3_sr,  opcode_op_imm}:   // SRAI
            begin
                o_decode.imm        = imm_shamt;
                o_decode.alu_op     = alu_op_of(i_inst.r_fmt.funct3, i_inst.r_fmt.funct7[5]);
                o_decode.use_imm    = 1'b1;
                o_decode.inst_class = class_alu;
            end

            {7'b???????, funct3_add_sub, opcode_op_imm},    // ADDI
            {7'b???????, funct3_slt,     opcode_op_imm},
            {7'b???????, funct3_sltu,    opcode_op_imm},
            {7'b???????, funct3_xor,     opcode_op_imm},
            {7'b???????, funct3_or,      opcode_op_imm},
            {7'b???????, funct3_and,     opcode_op_imm}:
            begin
                o_decode.imm        = imm_i;
                o_decode.alu_op     = alu_op_of(i_inst.r_fmt.funct3, 1'b0);  // Never SUB
                o_decode.use_imm    = 1'b1;
                o_decode.inst_class = class_alu;
            end

            {funct7_base, funct3_add_sub, opcode_op},
            {funct7_alt,  funct3_add_sub, opcode_op},
            {funct7_base, funct3_sll,     opcode_op},
            {funct7_base, funct3_slt,     opcode_op},
            {funct7_base, funct3_sltu,    opcode_op},
            {funct7_base, funct3_xor,     opcode_op},
            {funct7_base, funct3_sr,      opcode_op},
            {funct7_alt,  funct3_sr,      opcode_op},
            {funct7_base, funct3_or,      opcode_op},
            {funct7_base, funct3_and,     opcode_op}:
            begin
                o_decode.alu_op     = alu_op_of(i_inst.r_fmt.funct3, i_inst.r_fmt.funct7[5]);
                o_decode.inst_class = class_alu;
            end

            {funct7_muldiv, 3'b???, opcode_op}:     // MUL/DIV family
                o_decode.inst_class = RV_EXT_M ? class_deferred : class_illegal;

            {7'b???????, 3'b000, opcode_system}:
                case (i_inst.r_fmt.rs2)
                    5'd0:    o_decode.inst_class = class_ecall;
                    5'd1:    o_decode.inst_class = class_ebreak;
                    default: o_decode.inst_class = class_illegal;
                endcase

            {7'b???????, 3'b001, opcode_system},    // CSRRW
            {7'b???????, 3'b010, opcode_system},    // CSRRS
            {7'b???????, 3'b011, opcode_system},    // CSRRC
            {7'b???????, 3'b101, opcode_system},    // CSRRWI
            {7'b???????, 3'b110, opcode_system},    // CSRRSI
            {7'b???????, 3'b111, opcode_system}:    // CSRRCI
            begin
                o_decode.imm        = imm_i;        // CSR number in low 12 bits
                o_decode.inst_class = class_deferred;
            end

            default:
                o_decode.inst_class = class_illegal;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  rv_pkg::reg_addr_t i_rs1_addr,
    input  rv_pkg::reg_addr_t i_rs2_addr,
    output rv_pkg::data_t     o_rs1_data,
    output rv_pkg::data_t     o_rs2_data,
    input  logic              i_wr_en,
    input  rv_pkg::reg_addr_t i_wr_addr,
    input  rv_pkg::data_t     i_wr_data
);

    import rv_pkg::*;

    data_t regs [0:NUM_REGS-1];

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wr_en && (i_wr_addr != '0))  // x0 is hardwired
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Combinational reads with x0 forced to zero
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

// ==== design/retire_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_stage
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_valid,
    input  rv_pkg::data_t     i_pc,
    input  rv_pkg::decode_t   i_decode,
    input  rv_pkg::data_t     i_result,
    output logic              o_wr_en,
    output rv_pkg::reg_addr_t o_wr_addr,
    output rv_pkg::data_t     o_wr_data,
    output logic              o_retire_valid,
    output rv_pkg::retire_t   o_retire
);

    import rv_pkg::*;

    logic writes;

    // rd == 0 is filtered by the register file
    assign writes = (i_decode.inst_class == class_alu) ||
                    (i_decode.inst_class == class_upper);

    assign o_wr_en   = i_valid && writes;
    assign o_wr_addr = i_decode.rd;
    assign o_wr_data = i_result;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_retire_valid <= 1'b0;
        end
        else
        begin
            o_retire_valid <= i_valid;              // Offered for one cycle
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            o_retire.pc         <= i_pc;
            o_retire.rd         <= i_decode.rd;
            o_retire.result     <= writes ? i_result : '0;
            o_retire.wrote      <= writes;
            o_retire.inst_class <= i_decode.inst_class;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core
(
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_valid,
    input  rv_pkg::inst_u   i_inst,
    input  rv_pkg::data_t   i_pc,
    output logic            o_retire_valid,
    output rv_pkg::retire_t o_retire
);

    import rv_pkg::*;

    decode_t   decode;
    data_t     rs1_data;
    data_t     rs2_data;
    data_t     alu_a;
    data_t     alu_b;
    data_t     alu_result;
    logic      wr_en;
    reg_addr_t wr_addr;
    data_t     wr_data;

    inst_decoder u_decoder
    (
        .i_inst   (i_inst),
        .o_decode (decode)
    );

    reg_file u_reg_file
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rs1_addr (decode.rs1),
        .i_rs2_addr (decode.rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data)
    );

    // Operand selects driven by the decoder
    assign alu_a = decode.use_pc  ? i_pc       : rs1_data;
    assign alu_b = decode.use_imm ? decode.imm : rs2_data;

    alu u_alu
    (
        .i_op     (decode.alu_op),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    retire_stage u_retire
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_pc           (i_pc),
        .i_decode       (decode),
        .i_result       (alu_result),
        .o_wr_en        (wr_en),
        .o_wr_addr      (wr_addr),
        .o_wr_data      (wr_data),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire)
    );

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;
    localparam int SHAMT_W    = $clog2(XLEN);
    localparam bit RV_EXT_M   = 1'b0;            // No multiply/divide in this core

    // Major opcodes in bits 6:0
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_fence  = 7'b0001111;
    localparam logic [6:0] opcode_system = 7'b1110011;

    localparam logic [6:0] funct7_base   = 7'b0000000;
    localparam logic [6:0] funct7_alt    = 7'b0100000;  // SUB and SRA
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_sll     = 3'b001;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_sltu    = 3'b011;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_sr      = 3'b101;     // SRL and SRA
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;                 // imm[11:5] and the B-type high bits
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                 // imm[4:0] and the B-type low bits
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;                   // U immediate with J bits scrambled
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b                          // LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        class_alu,
        class_upper,                        // LUI and AUIPC
        class_deferred,                     // Decoded but not executed here
        class_ecall,
        class_ebreak,
        class_illegal
    } inst_class_e;

    typedef struct packed {
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        data_t       imm;
        alu_op_e     alu_op;
        logic        use_imm;               // Operand B from imm instead of rs2
        logic        use_pc;                // Operand A from pc instead of rs1
        inst_class_e inst_class;
    } decode_t;

    typedef struct packed {
        data_t       pc;
        reg_addr_t   rd;
        data_t       result;
        logic        wrote;
        inst_class_e inst_class;
    } retire_t;

endpackage

`default_nettype wire

// ==== rv_exec_core.f ====
+incdir+testbench
design/rv_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/alu.sv
design/retire_stage.sv
design/rv_exec_core.sv
testbench/tb_rv_exec_core.sv

// ==== testbench/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

data_t       shadow [0:NUM_REGS-1];         // Architectural register state
logic [31:0] rng_state = 32'd17;

function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input logic [2:0] f3,
                                       input reg_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                       input logic [2:0] f3, input reg_addr_t rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opcode_store};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input reg_addr_t rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcode_branch};
endfunction

// Result of an ALU or upper instruction against the shadow registers
function automatic data_t exec_result(input logic [31:0] word, input data_t pc_val);
    data_t      a;
    data_t      b;
    logic       alt;
    logic [4:0] sh;
    a   = shadow[word[19:15]];
    alt = word[30];
    if (word[6:0] == opcode_op)
        b = shadow[word[24:20]];
    else
        b = {{20{word[31]}}, word[31:20]};
    sh = b[4:0];
    if (word[6:0] == opcode_op_imm && word[14:12] == 3'b000)
        alt = 1'b0;                         // ADDI has no subtract form
    if (word[6:0] == opcode_lui)
        return {word[31:12], 12'b0};
    if (word[6:0] == opcode_auipc)
        return pc_val + {word[31:12], 12'b0};
    case (word[14:12])
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << sh;
        3'b010: return {31'b0, $signed(a) < $signed(b)};
        3'b011: return {31'b0, a < b};
        3'b100: return a ^ b;
        3'b101:
            if (alt)
                return $signed(a) >>> sh;
            else
                return a >> sh;
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic retire_t expected_retire(input logic [31:0] word, input data_t pc_val,
                                            input inst_class_e cls);
    retire_t rec;
    rec.pc         = pc_val;
    rec.rd         = word[11:7];
    rec.inst_class = cls;
    rec.wrote      = (cls == class_alu) || (cls == class_upper);
    rec.result     = rec.wrote ? exec_result(word, pc_val) : '0;
    return rec;
endfunction

`endif

// ==== testbench/tb_rv_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_core;

    import rv_pkg::*;

    localparam int NUM_RANDOM   = 200;
    localparam int NUM_DIRECTED = 100;       // Upper bound on directed instructions
    localparam int WATCHDOG_NS  = (NUM_RANDOM + NUM_DIRECTED) * 20 + 500;

    typedef struct packed {
        retire_t     rec;
        logic [31:0] cycle;                  // Cycle of the strobe
    } expect_t;

    logic    clk;
    logic    reset;
    logic    valid;
    inst_u   inst;
    data_t   pc;
    logic    retire_valid;
    retire_t retire;

    expect_t     exp_q [$];
    expect_t     head;
    logic [31:0] cycle_count = '0;
    data_t       pc_next = 32'h8000_0000;
    int          errors = 0;
    int          checked = 0;

    `include "tb_ref_model.svh"

    rv_exec_core u_dut
    (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_valid        (valid),
        .i_inst         (inst),
        .i_pc           (pc),
        .o_retire_valid (retire_valid),
        .o_retire       (retire)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 32'd1;
    end

    task automatic issue(input logic [31:0] word, input inst_class_e cls);
        expect_t entry;
        @(negedge clk);
        entry.rec   = expected_retire(word, pc_next, cls);
        entry.cycle = cycle_count;
        if (entry.rec.wrote && entry.rec.rd != '0)
            shadow[entry.rec.rd] = entry.rec.result;
        exp_q.push_back(entry);
        valid   = 1'b1;
        inst    = word;
        pc      = pc_next;
        pc_next = pc_next + 32'd4;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            valid = 1'b0;
            inst  = xorshift32();            // Junk must be ignored
            pc    = xorshift32();
        end
    endtask

    // ADDI xi, xi, 0 reports the current value of each register
    task automatic read_back(input int lo, input int hi);
        for (int i = lo; i <= hi; i++)
        begin
            issue(i_type(12'd0, reg_addr_t'(i), funct3_add_sub, reg_addr_t'(i), opcode_op_imm),
                  class_alu);
        end
    endtask

    task automatic random_alu();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        r   = xorshift32();
        f3  = r[2:0];
        rd  = {2'b00, r[5:3]};               // Small pool for many dependencies
        rs1 = {2'b00, r[8:6]};
        rs2 = {2'b00, r[11:9]};
        f7  = (r[12] && (f3 == 3'b000 || f3 == 3'b101)) ? funct7_alt : funct7_base;
        if (r[13])
            issue(r_type(f7, rs2, rs1, f3, rd, opcode_op), class_alu);
        else if (f3 == 3'b001 || f3 == 3'b101)
            issue(r_type(f7, r[20:16], rs1, f3, rd, opcode_op_imm), class_alu);
        else
            issue(i_type(r[31:20], rs1, f3, rd, opcode_op_imm), class_alu);
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (retire_valid)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    errors++;
                    $display("Retire reported at %0t with no instruction outstanding", $time);
                end
                if (exp_q.size() > 0)
                begin
                    head = exp_q.pop_front();
                    checked++;
                    assert (head.cycle == cycle_count - 32'd1)
                    else
                    begin
                        errors++;
                        $display("Retire for pc %h came %0d cycles after its strobe, not 1",
                                 head.rec.pc, cycle_count - head.cycle);
                    end
                    assert (retire === head.rec)
                    else
                    begin
                        errors++;
                        $display("FAILED %0t: got pc %h rd %0d result %h wrote %0b class %0d,",
                                 $time, retire.pc, retire.rd, retire.result, retire.wrote,
                                 retire.inst_class);
                        $display("    expected pc %h rd %0d result %h wrote %0b class %0d",
                                 head.rec.pc, head.rec.rd, head.rec.result, head.rec.wrote,
                                 head.rec.inst_class);
                    end
                end
            end
            else if (exp_q.size() > 0)
            begin
                head = exp_q[0];
                assert (head.cycle == cycle_count)  // Only a strobe from this cycle may wait
                else
                begin
                    errors++;
                    $display("Missing retire for the instruction at pc %h", head.rec.pc);
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Retires checked: %0d, errors: %0d", checked, errors + 1);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        logic [31:0] gap;
        logic [31:0] rnd;
        reset = 1'b1;
        valid = 1'b0;
        inst  = '0;
        pc    = '0;
        for (int i = 0; i < NUM_REGS; i++)
            shadow[i] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idle(3);

        issue(r_type(funct7_base, 5'd0, 5'd0, funct3_add_sub, 5'd5, opcode_op), class_alu);
        read_back(0, NUM_REGS - 1);          // All zero after reset

        for (int i = 1; i < 8; i++)          // Random signed operands
        begin
            rnd = xorshift32();
            issue(u_type(rnd[31:12], reg_addr_t'(i), opcode_lui), class_upper);
            rnd = xorshift32();
            issue(i_type(rnd[31:20], reg_addr_t'(i), funct3_add_sub, reg_addr_t'(i),
                         opcode_op_imm), class_alu);
        end
        idle(2);

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            random_alu();
            gap = xorshift32();
            if (gap[1:0] == 2'b00)
                idle(1 + gap[3:2] % 3);
        end

        issue(u_type(20'habcde, 5'd7, opcode_lui), class_upper);
        issue(u_type(20'h12345, 5'd6, opcode_auipc), class_upper);
        issue(u_type(20'hfffff, 5'd0, opcode_lui), class_upper);    // Reported but not kept
        issue(r_type(funct7_base, 5'd0, 5'd0, funct3_add_sub, 5'd6, opcode_op), class_alu);
        issue(u_type(20'h00001, 5'd0, opcode_auipc), class_upper);
        issue(r_type(funct7_base, 5'd6, 5'd7, funct3_add_sub, 5'd1, opcode_op), class_alu);
        idle(1);

        issue(i_type(12'd8, 5'd1, 3'b010, 5'd3, opcode_load), class_deferred);       // LW
        issue(i_type(12'hffc, 5'd2, 3'b100, 5'd4, opcode_load), class_deferred);     // LBU
        issue(s_type(12'd4, 5'd2, 5'd1, 3'b010), class_deferred);                    // SW
        issue(s_type(12'h800, 5'd3, 5'd5, 3'b000), class_deferred);                  // SB
        issue(b_type(13'd16, 5'd2, 5'd1, 3'b000), class_deferred);                   // BEQ
        issue(b_type(13'h1ff0, 5'd4, 5'd3, 3'b111), class_deferred);                 // BGEU
        issue(u_type(20'h12345, 5'd1, opcode_jal), class_deferred);
        issue(i_type(12'd0, 5'd5, 3'b000, 5'd1, opcode_jalr), class_deferred);
        issue(i_type(12'h300, 5'd1, 3'b001, 5'd4, opcode_system), class_deferred);   // CSRRW
        issue(i_type(12'h341, 5'd7, 3'b110, 5'd2, opcode_system), class_deferred);   // CSRRSI
        read_back(0, 7);                     // Deferred ones left no trace

        issue(i_type(12'd0, 5'd0, 3'b000, 5'd0, opcode_system), class_ecall);
        issue(i_type(12'd1, 5'd0, 3'b000, 5'd0, opcode_system), class_ebreak);
        issue(i_type(12'd2, 5'd0, 3'b000, 5'd0, opcode_system), class_illegal);
        issue(i_type(12'h0ff, 5'd0, 3'b000, 5'd0, opcode_fence), class_illegal);
        issue(r_type(funct7_muldiv, 5'd2, 5'd1, 3'b000, 5'd3, opcode_op), class_illegal);
        issue(r_type(funct7_muldiv, 5'd2, 5'd1, 3'b100, 5'd4, opcode_op), class_illegal);
        issue(i_type(12'd0, 5'd1, 3'b011, 5'd5, opcode_load), class_illegal);        // LD
        issue(32'hffff_ffff, class_illegal);
        issue(u_type(20'h0, 5'd6, 7'b0001011), class_illegal);                       // custom-0
        read_back(3, 6);
        idle(2);

        wait (exp_q.size() == 0);
        idle(3);
        $display("Retires checked: %0d, errors: %0d", checked, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
